//--- src/fetch_pkg.sv
// shared widths, opcodes and payload types for the fetch expander, imported by its RTL and testbench
package fetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  // instruction, fetch word and pc width
  localparam int xlen = 32;
  // one compressed parcel
  localparam int parcel_w = 16;

  //////////////////////////////////////////////////////////////////////
  // major opcodes of the expanded instructions
  //////////////////////////////////////////////////////////////////////

  localparam logic [6:0] opcode_op     = 7'h33;
  localparam logic [6:0] opcode_opimm  = 7'h13;
  localparam logic [6:0] opcode_load   = 7'h03;
  localparam logic [6:0] opcode_store  = 7'h23;
  localparam logic [6:0] opcode_branch = 7'h63;
  localparam logic [6:0] opcode_jal    = 7'h6f;
  localparam logic [6:0] opcode_jalr   = 7'h67;
  localparam logic [6:0] opcode_lui    = 7'h37;

  //////////////////////////////////////////////////////////////////////
  // buffering
  //////////////////////////////////////////////////////////////////////

  // input side, fetch words waiting for the aligner
  localparam int fetch_fifo_depth = 2;
  // output side, expanded instructions waiting for decode
  localparam int out_fifo_depth = 2;

  //////////////////////////////////////////////////////////////////////
  // payload types
  //////////////////////////////////////////////////////////////////////

  // one aligned fetch word, two parcels
  typedef logic [xlen-1:0] fetch_word_t;

  // expanded instruction with its address and flags
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
    // set when the source was a 16-bit parcel
    logic            is_compressed;
    // set for reserved or malformed compressed encodings
    logic            illegal;
  } decoded_instr_t;

endpackage

//--- src/stream_fifo.sv
// valid/ready FIFO for any payload type, used on both sides of the aligner and decoder
module stream_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  depth     = 2
) (
  input  logic     clk,
  input  logic     reset_i,
  input  logic     push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,
  output logic     pop_valid_o,
  output payload_t pop_data_o,
  input  logic     pop_ready_i
);

  typedef logic [$clog2(depth)-1:0]   ptr_t;
  typedef logic [$clog2(depth+1)-1:0] count_t;

  // storage, payload only
  payload_t mem_q [depth];
  ptr_t     wr_ptr_q;
  ptr_t     rd_ptr_q;
  count_t   count_q;
  logic     push;
  logic     pop;
  logic     full;

  assign full = (count_q == count_t'(depth));

  // full blocks a push unless the head leaves in the same cycle
  assign push_ready_o = !full || pop_ready_i;
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  //////////////////////////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        // wrap at the last slot, depth need not be a power of two
        wr_ptr_q <= (wr_ptr_q == ptr_t'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // data written at the tail, seen at the head a cycle later
  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

//--- src/instr_aligner.sv
// splits aligned fetch words into whole 16- or 32-bit instructions and tracks their pc
module instr_aligner import fetch_pkg::*; (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            word_valid_i,
  input  fetch_word_t     word_i,
  output logic            word_ready_o,
  output logic            instr_valid_o,
  output logic [xlen-1:0] instr_o,
  output logic [xlen-1:0] pc_o,
  input  logic            instr_ready_i
);

  // what the parcel register currently holds
  typedef enum logic [1:0] {
    hold_empty,
    hold_comp,
    hold_half
  } hold_state_t;

  hold_state_t         state_q;
  hold_state_t         state_d;
  logic [parcel_w-1:0] held_q;
  logic [parcel_w-1:0] held_d;
  logic [xlen-1:0]     pc_q;
  logic [parcel_w-1:0] low_parcel;
  logic [parcel_w-1:0] high_parcel;
  logic                word_take;
  logic                accept;
  logic                emit_half;

  // low bits 11 mark a 32-bit instruction, anything else is compressed
  function automatic logic parcel_is_full(input logic [parcel_w-1:0] parcel);
    return parcel[1:0] == 2'b11;
  endfunction

  assign low_parcel  = word_i[parcel_w-1:0];
  assign high_parcel = word_i[xlen-1:parcel_w];

  // a word leaves the input FIFO only together with an accepted instruction
  assign word_take = word_valid_i && instr_ready_i;
  assign accept    = instr_valid_o && instr_ready_i;
  assign pc_o      = pc_q;

  //////////////////////////////////////////////////////////////////////
  // emit and hold
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    held_d        = held_q;
    instr_valid_o = 1'b0;
    instr_o       = '0;
    word_ready_o  = 1'b0;
    emit_half     = 1'b0;

    case (state_q)
      hold_comp: begin
        // held compressed parcel goes out, no word needed
        instr_valid_o = 1'b1;
        instr_o       = {{parcel_w{1'b0}}, held_q};
        emit_half     = 1'b1;
        if (instr_ready_i) begin
          state_d = hold_empty;
        end
      end

      hold_half: begin
        // held low half joins the new word's low parcel
        instr_valid_o = word_valid_i;
        instr_o       = {low_parcel, held_q};
        word_ready_o  = instr_ready_i;
        if (word_take) begin
          held_d  = high_parcel;
          state_d = parcel_is_full(high_parcel) ? hold_half : hold_comp;
        end
      end

      default: begin
        instr_valid_o = word_valid_i;
        word_ready_o  = instr_ready_i;
        if (parcel_is_full(low_parcel)) begin
          // aligned 32-bit instruction, whole word used
          instr_o = word_i;
        end else begin
          instr_o   = {{parcel_w{1'b0}}, low_parcel};
          emit_half = 1'b1;
          // upper parcel kept for the next cycle
          if (word_take) begin
            held_d  = high_parcel;
            state_d = parcel_is_full(high_parcel) ? hold_half : hold_comp;
          end
        end
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state and pc
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= hold_empty;
      pc_q    <= '0;
    end else begin
      state_q <= state_d;
      // step by the length of the instruction just taken
      if (accept) begin
        pc_q <= pc_q + (emit_half ? xlen'(2) : xlen'(4));
      end
    end
  end

  always_ff @(posedge clk) begin
    held_q <= held_d;
  end

endmodule

//--- src/compressed_decoder.sv
// combinational expander from compressed parcels to 32-bit instructions, with illegal flag
module compressed_decoder import fetch_pkg::*; (
  input  logic [xlen-1:0] instr_i,
  output logic [xlen-1:0] instr_o,
  output logic            is_compressed_o,
  output logic            illegal_instr_o
);

  // full register fields
  logic [4:0]  rd;
  logic [4:0]  rs2;
  // short register fields, x8 to x15
  logic [4:0]  rd_lo;
  logic [4:0]  rs1_c;
  logic [4:0]  rd_hi;
  // sign-extended 6-bit immediate
  logic [11:0] imm6;
  logic        sgn;

  assign rd    = instr_i[11:7];
  assign rs2   = instr_i[6:2];
  assign rd_lo = {2'b01, instr_i[4:2]};
  assign rs1_c = {2'b01, instr_i[9:7]};
  assign rd_hi = {2'b01, instr_i[12:10]};
  assign sgn   = instr_i[12];
  assign imm6  = {{7{sgn}}, instr_i[6:2]};

  always_comb begin
    illegal_instr_o = 1'b0;
    is_compressed_o = 1'b1;
    instr_o         = '0;

    case (instr_i[1:0])
      //////////////////////////////////////////////////////////////////
      // quadrant 0
      //////////////////////////////////////////////////////////////////
      2'b00: begin
        case (instr_i[15:13])
          3'b000: begin
            // c.mv when bit 12 clear, c.add otherwise
            if (!sgn) begin
              instr_o = {7'b0, rs2, 5'b0, 3'b000, rd, opcode_op};
            end else begin
              instr_o = {7'b0, rs2, rd, 3'b000, rd, opcode_op};
            end
            illegal_instr_o = (rd == 5'b0);
          end
          3'b001: begin
            // c.srai
            instr_o = {2'b01, 5'b0, rs2, rd, 3'b101, rd, opcode_opimm};
            illegal_instr_o = sgn || (rs2 == 5'b0) || (rd == 5'b0);
          end
          3'b010: begin
            // c.sw, word offset from bits 5, 12, 11:10, 6
            instr_o = {5'b0, instr_i[5], instr_i[12], rd_lo, rs1_c, 3'b010,
                       instr_i[11:10], instr_i[6], 2'b00, opcode_store};
          end
          3'b011: begin
            // register-register ops on short registers
            case ({instr_i[12:10], instr_i[6:5]})
              5'b00000: instr_o = {7'b0, rd_lo, rs1_c, 3'b100, rs1_c, opcode_op};
              5'b00101: instr_o = {7'b0, rd_lo, rs1_c, 3'b101, rs1_c, opcode_op};
              5'b01100: instr_o = {7'b0, rd_lo, rd_lo, 3'b001, rd_lo, opcode_op};
              5'b01111: instr_o = {7'b0, rd_lo, rs1_c, 3'b011, rd_lo, opcode_op};
              default:  illegal_instr_o = 1'b1;
            endcase
          end
          3'b100: begin
            // c.sub
            instr_o = {2'b01, 5'b0, rs2, rd, 3'b000, rd, opcode_op};
            illegal_instr_o = sgn || (rs2 == 5'b0) || (rd == 5'b0);
          end
          3'b101: begin
            // three-operand forms, destination in bits 12:10
            case (instr_i[6:5])
              2'b00:   instr_o = {7'b0, rd_lo, rs1_c, 3'b000, rd_hi, opcode_op};
              2'b01:   instr_o = {2'b01, 5'b0, rd_lo, rs1_c, 3'b000, rd_hi, opcode_op};
              2'b10:   instr_o = {7'b0, rd_lo, rs1_c, 3'b110, rd_hi, opcode_op};
              default: instr_o = {7'b0, rd_lo, rs1_c, 3'b111, rd_hi, opcode_op};
            endcase
          end
          3'b110: begin
            // c.lw
            instr_o = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                       rs1_c, 3'b010, rd_lo, opcode_load};
          end
          default: illegal_instr_o = 1'b1;
        endcase
      end

      //////////////////////////////////////////////////////////////////
      // quadrant 1
      //////////////////////////////////////////////////////////////////
      2'b01: begin
        case (instr_i[15:13])
          3'b000, 3'b001: begin
            // c.slli and c.srli, shift amount must be nonzero
            instr_o = {7'b0, rs2, rd, instr_i[13] ? 3'b101 : 3'b001, rd, opcode_opimm};
            illegal_instr_o = sgn || (rs2 == 5'b0) || (rd == 5'b0);
          end
          3'b010: begin
            // c.swsp
            instr_o = {4'b0, instr_i[8:7], instr_i[12], rs2, 5'h02, 3'b010,
                       instr_i[11:9], 2'b00, opcode_store};
          end
          3'b100: begin
            // immediate ops on short registers, imm bit 11 stays clear
            case (instr_i[6:5])
              2'b00: instr_o = {1'b0, {8{sgn}}, instr_i[12:10], rs1_c, 3'b000, rd_lo,
                                opcode_opimm};
              2'b01: instr_o = {1'b0, {8{sgn}}, instr_i[12:10], rs1_c, 3'b100, rd_lo,
                                opcode_opimm};
              2'b10: instr_o = {1'b0, {8{sgn}}, instr_i[12:10], rs1_c, 3'b110, rd_lo,
                                opcode_opimm};
              default: instr_o = {1'b0, {8{sgn}}, instr_i[12:10], rs1_c, 3'b111, rd_lo,
                                  opcode_opimm};
            endcase
            illegal_instr_o = (instr_i[12:10] == 3'b0);
          end
          3'b101: begin
            // c.addi4spn
            instr_o = {2'b0, instr_i[10:7], instr_i[12:11], instr_i[5], instr_i[6], 2'b00,
                       5'h02, 3'b000, rd_lo, opcode_opimm};
          end
          3'b110: begin
            // c.lwsp
            instr_o = {4'b0, instr_i[3:2], instr_i[12], instr_i[6:4], 2'b00,
                       5'h02, 3'b010, rd, opcode_load};
            illegal_instr_o = (rd == 5'b0);
          end
          default: illegal_instr_o = 1'b1;
        endcase
      end

      //////////////////////////////////////////////////////////////////
      // quadrant 2
      //////////////////////////////////////////////////////////////////
      2'b10: begin
        case (instr_i[15:13])
          3'b000, 3'b001: begin
            // c.j and c.jal, bit 13 picks the link register
            instr_o = {sgn, instr_i[11:7], instr_i[2], instr_i[6:3], {9{sgn}},
                       4'b0, instr_i[13], opcode_jal};
          end
          3'b010, 3'b011: begin
            // c.beqz and c.bnez against x0
            instr_o = {{3{sgn}}, instr_i[12:10], instr_i[2], 5'b0, rs1_c, 2'b00,
                       instr_i[13], instr_i[6:3], sgn, opcode_branch};
          end
          3'b100: begin
            // c.jr with zero immediate, c.li otherwise
            if ({sgn, rs2} == 6'b0) begin
              instr_o = {12'b0, rd, 3'b000, 5'b0, opcode_jalr};
            end else begin
              instr_o = {imm6, 5'b0, 3'b000, rd, opcode_opimm};
            end
            illegal_instr_o = (rd == 5'b0);
          end
          3'b101: begin
            // c.jalr with zero immediate, c.lui otherwise
            if ({sgn, rs2} == 6'b0) begin
              instr_o = {12'b0, rd, 3'b000, 5'b00001, opcode_jalr};
            end else begin
              instr_o = {{15{sgn}}, rs2, rd, opcode_lui};
            end
            illegal_instr_o = (rd == 5'b0);
          end
          3'b110: begin
            // c.addi16sp when rd is x0, c.addi otherwise
            if (rd == 5'b0) begin
              instr_o = {{3{sgn}}, instr_i[4:2], instr_i[5], instr_i[6], 4'b0,
                         5'h02, 3'b000, 5'h02, opcode_opimm};
            end else begin
              instr_o = {imm6, rd, 3'b000, rd, opcode_opimm};
            end
            illegal_instr_o = ({sgn, rs2} == 6'b0);
          end
          default: begin
            // c.andi
            instr_o = {imm6, rd, 3'b111, rd, opcode_opimm};
            illegal_instr_o = (rd == 5'b0);
          end
        endcase
      end

      default: begin
        // full-length instruction, unchanged
        instr_o         = instr_i;
        is_compressed_o = 1'b0;
      end
    endcase
  end

endmodule

//--- src/fetch_expander.sv
// top of the fetch-side expander, fetch words in and expanded instructions with pc out
module fetch_expander import fetch_pkg::*; (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            fetch_valid_i,
  input  fetch_word_t     fetch_word_i,
  output logic            fetch_ready_o,
  output logic            out_valid_o,
  output logic [xlen-1:0] out_pc_o,
  output logic [xlen-1:0] out_instr_o,
  output logic            out_is_compressed_o,
  output logic            out_illegal_o,
  input  logic            out_ready_i
);

  // input FIFO to aligner
  logic            word_valid;
  logic            word_ready;
  fetch_word_t     word;
  // aligner to decoder and output FIFO
  logic            instr_valid;
  logic            instr_ready;
  logic [xlen-1:0] raw_instr;
  logic [xlen-1:0] raw_pc;
  // decoder results
  logic [xlen-1:0] exp_instr;
  logic            is_compressed;
  logic            illegal;
  decoded_instr_t  dec_push;
  decoded_instr_t  dec_pop;

  stream_fifo #(
    .payload_t(fetch_word_t),
    .depth    (fetch_fifo_depth)
  ) fetch_fifo_inst (
    .clk         (clk),
    .reset_i     (reset_i),
    .push_valid_i(fetch_valid_i),
    .push_data_i (fetch_word_i),
    .push_ready_o(fetch_ready_o),
    .pop_valid_o (word_valid),
    .pop_data_o  (word),
    .pop_ready_i (word_ready)
  );

  instr_aligner aligner_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .word_valid_i (word_valid),
    .word_i       (word),
    .word_ready_o (word_ready),
    .instr_valid_o(instr_valid),
    .instr_o      (raw_instr),
    .pc_o         (raw_pc),
    .instr_ready_i(instr_ready)
  );

  // expansion sits in the aligner to output FIFO path
  compressed_decoder decoder_inst (
    .instr_i        (raw_instr),
    .instr_o        (exp_instr),
    .is_compressed_o(is_compressed),
    .illegal_instr_o(illegal)
  );

  assign dec_push = '{pc: raw_pc, instr: exp_instr, is_compressed: is_compressed,
                      illegal: illegal};

  stream_fifo #(
    .payload_t(decoded_instr_t),
    .depth    (out_fifo_depth)
  ) out_fifo_inst (
    .clk         (clk),
    .reset_i     (reset_i),
    .push_valid_i(instr_valid),
    .push_data_i (dec_push),
    .push_ready_o(instr_ready),
    .pop_valid_o (out_valid_o),
    .pop_data_o  (dec_pop),
    .pop_ready_i (out_ready_i)
  );

  assign out_pc_o            = dec_pop.pc;
  assign out_instr_o         = dec_pop.instr;
  assign out_is_compressed_o = dec_pop.is_compressed;
  assign out_illegal_o       = dec_pop.illegal;

endmodule

//--- sim/fetch_expander_properties.sv
// handshake and reset assertions for the fetch expander, attached to the top level by bind
module fetch_expander_properties import fetch_pkg::*; (
  input logic            clk,
  input logic            reset_i,
  input logic            fetch_valid_i,
  input fetch_word_t     fetch_word_i,
  input logic            fetch_ready_o,
  input logic            out_valid_o,
  input logic [xlen-1:0] out_pc_o,
  input logic [xlen-1:0] out_instr_o,
  input logic            out_is_compressed_o,
  input logic            out_illegal_o,
  input logic            out_ready_i
);

  //////////////////////////////////////////////////////////////////////
  // reset
  //////////////////////////////////////////////////////////////////////

  // output FIFO empty during and right after reset
  reset_quiet: assert property (@(posedge clk) reset_i |=> !out_valid_o)
    else $error("out_valid_o high after a reset cycle");

  //////////////////////////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////////////////////////

  // stalled result keeps valid and every field
  out_stable: assert property (@(posedge clk) disable iff (reset_i)
    (out_valid_o && !out_ready_i) |=>
      (out_valid_o && $stable(out_pc_o) && $stable(out_instr_o)
       && $stable(out_is_compressed_o) && $stable(out_illegal_o)))
    else $error("output changed while stalled");

  // stalled fetch word held by the source
  fetch_stable: assert property (@(posedge clk) disable iff (reset_i)
    (fetch_valid_i && !fetch_ready_o) |=> (fetch_valid_i && $stable(fetch_word_i)))
    else $error("fetch word changed while stalled");

endmodule

bind fetch_expander fetch_expander_properties props_inst (
  .clk                (clk),
  .reset_i            (reset_i),
  .fetch_valid_i      (fetch_valid_i),
  .fetch_word_i       (fetch_word_i),
  .fetch_ready_o      (fetch_ready_o),
  .out_valid_o        (out_valid_o),
  .out_pc_o           (out_pc_o),
  .out_instr_o        (out_instr_o),
  .out_is_compressed_o(out_is_compressed_o),
  .out_illegal_o      (out_illegal_o),
  .out_ready_i        (out_ready_i)
);

//--- sim/fetch_expander_tb.sv
// testbench for the fetch expander, drives a word table and checks the expanded stream
module fetch_expander_tb import fetch_pkg::*; ();

  localparam int clk_period   = 40;
  localparam int reset_cycles = 5;
  localparam int idle_cycles  = 4;
  localparam int num_words    = 8;
  localparam int num_exp      = 12;
  // 40 cycles for every table entry on top of reset
  localparam int watchdog_time = (reset_cycles + 40 * (num_words + num_exp)) * clk_period;

  logic            clk;
  logic            reset_i;
  logic            fetch_valid_i;
  fetch_word_t     fetch_word_i;
  logic            fetch_ready_o;
  logic            out_valid_o;
  logic [xlen-1:0] out_pc_o;
  logic [xlen-1:0] out_instr_o;
  logic            out_is_compressed_o;
  logic            out_illegal_o;
  logic            out_ready_i;

  fetch_word_t    stim_words [num_words];
  decoded_instr_t exp_table [num_exp];
  int             seed;
  int             seen;

  fetch_expander fetch_expander_inst (
    .clk                (clk),
    .reset_i            (reset_i),
    .fetch_valid_i      (fetch_valid_i),
    .fetch_word_i       (fetch_word_i),
    .fetch_ready_o      (fetch_ready_o),
    .out_valid_o        (out_valid_o),
    .out_pc_o           (out_pc_o),
    .out_instr_o        (out_instr_o),
    .out_is_compressed_o(out_is_compressed_o),
    .out_illegal_o      (out_illegal_o),
    .out_ready_i        (out_ready_i)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////
  // stimulus and expected results
  ////////////////////////////////////////////////////////////////////

  task automatic load_tables();
    // two aligned 32-bit words
    stim_words[0] = 32'h00a0_0093;
    stim_words[1] = 32'h0020_81b3;
    // c.add x5,x6 low, c.lw x10,72(x9) high
    stim_words[2] = 32'hc4a8_1298;
    // c.sw x11 low, c.slli x7,3 high
    stim_words[3] = 32'h038d_584c;
    // c.li x12,5 low, first half of addi x1,x0,10 high
    stim_words[4] = 32'h0093_8616;
    // second half of the addi, then c.mv with rd zero
    stim_words[5] = 32'h0014_00a0;
    // c.slli with zero shift, then c.srli x8,4
    stim_words[6] = 32'h2411_0381;
    stim_words[7] = 32'hfe01_0113;

    // pc, instr, is_compressed, illegal
    exp_table[0]  = '{32'h00, 32'h00a0_0093, 1'b0, 1'b0};
    exp_table[1]  = '{32'h04, 32'h0020_81b3, 1'b0, 1'b0};
    exp_table[2]  = '{32'h08, 32'h0062_82b3, 1'b1, 1'b0};
    exp_table[3]  = '{32'h0a, 32'h0484_a503, 1'b1, 1'b0};
    exp_table[4]  = '{32'h0c, 32'h02b4_2a23, 1'b1, 1'b0};
    exp_table[5]  = '{32'h0e, 32'h0033_9393, 1'b1, 1'b0};
    exp_table[6]  = '{32'h10, 32'h0050_0613, 1'b1, 1'b0};
    // reassembled across words 4 and 5
    exp_table[7]  = '{32'h12, 32'h00a0_0093, 1'b0, 1'b0};
    exp_table[8]  = '{32'h16, 32'h0050_0033, 1'b1, 1'b1};
    exp_table[9]  = '{32'h18, 32'h0003_9393, 1'b1, 1'b1};
    exp_table[10] = '{32'h1a, 32'h0044_5413, 1'b1, 1'b0};
    exp_table[11] = '{32'h1c, 32'hfe01_0113, 1'b0, 1'b0};
  endtask

  ////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////

  task automatic report_error(input string msg);
    $display("** Error at time %0t: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_decoded(input decoded_instr_t got, input decoded_instr_t exp,
                               input int idx);
    if (got !== exp) begin
      report_error($sformatf(
        "result %0d pc %h instr %h c %b ill %b, expected pc %h instr %h c %b ill %b",
        idx, got.pc, got.instr, got.is_compressed, got.illegal,
        exp.pc, exp.instr, exp.is_compressed, exp.illegal));
    end
  endtask

  // 32-bit instruction must come out as fetched, both flags clear
  task automatic check_passthrough(input fetch_word_t got, input fetch_word_t exp,
                                   input logic comp, input logic ill, input int idx);
    if (got !== exp || comp !== 1'b0 || ill !== 1'b0) begin
      report_error($sformatf("passthrough %0d got %h flags %b%b, expected %h flags 00",
                             idx, got, comp, ill, exp));
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // stream processes
  ////////////////////////////////////////////////////////////////////

  // nothing may come out before the first word
  task automatic check_quiet(input int cycles, input logic ready_exp);
    repeat (cycles) begin
      @(negedge clk);
      check_flag("out_valid_o while idle", out_valid_o, 1'b0);
      check_flag("fetch_ready_o while idle", fetch_ready_o, ready_exp);
    end
  endtask

  task automatic drive_words();
    logic taken;
    for (int i = 0; i < num_words; i++) begin
      fetch_valid_i <= 1'b1;
      fetch_word_i  <= stim_words[i];
      // hold the word until the input FIFO has room
      do begin
        @(negedge clk);
        taken = fetch_ready_o;
        @(posedge clk);
      end while (!taken);
    end
    fetch_valid_i <= 1'b0;
  endtask

  task automatic collect_results();
    decoded_instr_t got;
    while (seen < num_exp) begin
      @(negedge clk);
      // transfer happens on the coming rising edge
      if (out_valid_o && out_ready_i) begin
        got = '{pc: out_pc_o, instr: out_instr_o, is_compressed: out_is_compressed_o,
                illegal: out_illegal_o};
        if (!exp_table[seen].is_compressed) begin
          check_passthrough(out_instr_o, exp_table[seen].instr, out_is_compressed_o,
                            out_illegal_o, seen);
        end
        check_decoded(got, exp_table[seen], seen);
        seen++;
      end
    end
  endtask

  // random back-pressure on the output side
  initial begin : ready_gen
    logic [31:0] rnd;
    forever begin
      @(posedge clk);
      rnd = $random(seed);
      out_ready_i <= reset_i ? 1'b0 : rnd[0];
    end
  end

  initial begin : watchdog
    #(watchdog_time);
    $display("watchdog expired at %0t with %0d of %0d results", $time, seen, num_exp);
    $display("Verification failed");
    $fatal(1, "simulation timed out");
  end

  initial begin : main_flow
    reset_i       = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_word_i  = '0;
    out_ready_i   = 1'b0;
    seed          = 32'hb46d_1dc2;
    seen          = 0;
    load_tables();

    repeat (reset_cycles) @(posedge clk);
    reset_i <= 1'b0;
    @(posedge clk);
    check_quiet(idle_cycles, 1'b1);
    @(posedge clk);

    fork
      drive_words();
      collect_results();
    join

    // no extra or repeated result after the table
    check_quiet(8, 1'b1);

    $display("Verification passed");
    $finish;
  end

endmodule

//--- project.f
src/fetch_pkg.sv
src/stream_fifo.sv
src/instr_aligner.sv
src/compressed_decoder.sv
src/fetch_expander.sv
sim/fetch_expander_properties.sv
sim/fetch_expander_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the fetch expander testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim_run.log

verilator --binary --timing --assert \
  --top-module fetch_expander_tb -f project.f -o fetch_expander_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/fetch_expander_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Verification passed" "$log"; then
  exit 0
else
  echo "pass line not found in $log"
  exit 1
fi
